// ==== hdl/gcc_point_pkg.sv ====
// Point field types, slot index and fill count types, window size and fill limit
`default_nettype none

package gcc_point_pkg;

    // ------------------------------------------------
    // Point fields
    // ------------------------------------------------
    typedef logic [7:0] coord_t;
    typedef logic [3:0] weight_t;

    // ------------------------------------------------
    // Window bookkeeping
    // ------------------------------------------------
    // Slot number 0 to 5
    typedef logic [2:0] slot_idx_t;
    typedef logic [2:0] fill_cnt_t;

    localparam int WINDOW_SLOTS = 6;

    // First shift loads the empty pending point, six more load real points
    localparam fill_cnt_t FILL_DONE = 3'd7;

endpackage

`default_nettype wire

// ==== hdl/gcc_arith_pkg.sv ====
// Widths of weight sums, weighted coordinate sums, rounding dividends and distances
`default_nettype none

package gcc_arith_pkg;

    // ------------------------------------------------
    // Centre datapath
    // ------------------------------------------------
    // Six weights of at most 15
    typedef logic [6:0]  wsum_t;

    // Six products of at most 255 * 15
    typedef logic [14:0] csum_t;

    // Weighted sum plus half the weight sum
    typedef logic [15:0] dividend_t;

    // ------------------------------------------------
    // Victim search
    // ------------------------------------------------
    // Two squared axis offsets, each at most 255 * 255
    typedef logic [16:0] dist_t;

endpackage

`default_nettype wire

// ==== hdl/point_window.sv ====
// Pending point register, six window slots, fill counter and next-window select
`default_nettype none

module point_window (
    input  wire                           CLK,
    input  wire                           RESET_,
    input  wire gcc_point_pkg::coord_t    xi,
    input  wire gcc_point_pkg::coord_t    yi,
    input  wire gcc_point_pkg::weight_t   wi,
    input  wire gcc_point_pkg::slot_idx_t victim,
    output gcc_point_pkg::coord_t         pend_x,
    output gcc_point_pkg::coord_t         pend_y,
    output gcc_point_pkg::weight_t        pend_w,
    output gcc_point_pkg::coord_t         slot_x_0, slot_x_1, slot_x_2,
                                          slot_x_3, slot_x_4, slot_x_5,
    output gcc_point_pkg::coord_t         slot_y_0, slot_y_1, slot_y_2,
                                          slot_y_3, slot_y_4, slot_y_5,
    output gcc_point_pkg::weight_t        slot_w_0, slot_w_1, slot_w_2,
                                          slot_w_3, slot_w_4, slot_w_5,
    output gcc_point_pkg::coord_t         next_x_0, next_x_1, next_x_2,
                                          next_x_3, next_x_4, next_x_5,
    output gcc_point_pkg::coord_t         next_y_0, next_y_1, next_y_2,
                                          next_y_3, next_y_4, next_y_5,
    output gcc_point_pkg::weight_t        next_w_0, next_w_1, next_w_2,
                                          next_w_3, next_w_4, next_w_5,
    output gcc_point_pkg::fill_cnt_t      fill_cnt
);

    import gcc_point_pkg::*;

    coord_t  sx [WINDOW_SLOTS];
    coord_t  sy [WINDOW_SLOTS];
    weight_t sw [WINDOW_SLOTS];
    coord_t  nx [WINDOW_SLOTS];
    coord_t  ny [WINDOW_SLOTS];
    weight_t nw [WINDOW_SLOTS];
    logic    replace_mode;

    // ------------------------------------------------
    // Pending point and fill counter
    // ------------------------------------------------
    always_ff @(posedge CLK or negedge RESET_) begin
        if (!RESET_) begin
            pend_x   <= '0;
            pend_y   <= '0;
            pend_w   <= '0;
            fill_cnt <= '0;
        end else begin
            pend_x <= xi;
            pend_y <= yi;
            pend_w <= wi;
            // Saturates once the window is full
            if (fill_cnt != FILL_DONE) begin
                fill_cnt <= fill_cnt + fill_cnt_t'(1);
            end
        end
    end

    assign replace_mode = (fill_cnt == FILL_DONE);

    // ------------------------------------------------
    // Next window
    // ------------------------------------------------
    always_comb begin
        if (!replace_mode) begin
            // Shift in at slot 0, oldest falls out of slot 5
            nx[0] = pend_x;
            ny[0] = pend_y;
            nw[0] = pend_w;
            for (int i = 1; i < WINDOW_SLOTS; i++) begin
                nx[i] = sx[i - 1];
                ny[i] = sy[i - 1];
                nw[i] = sw[i - 1];
            end
        end else begin
            for (int i = 0; i < WINDOW_SLOTS; i++) begin
                if (victim == slot_idx_t'(i)) begin
                    nx[i] = pend_x;
                    ny[i] = pend_y;
                    nw[i] = pend_w;
                end else begin
                    nx[i] = sx[i];
                    ny[i] = sy[i];
                    nw[i] = sw[i];
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge RESET_) begin
        if (!RESET_) begin
            for (int i = 0; i < WINDOW_SLOTS; i++) begin
                sx[i] <= '0;
                sy[i] <= '0;
                sw[i] <= '0;
            end
        end else begin
            sx <= nx;
            sy <= ny;
            sw <= nw;
        end
    end

    // Current window to the victim search
    assign slot_x_0 = sx[0];
    assign slot_x_1 = sx[1];
    assign slot_x_2 = sx[2];
    assign slot_x_3 = sx[3];
    assign slot_x_4 = sx[4];
    assign slot_x_5 = sx[5];
    assign slot_y_0 = sy[0];
    assign slot_y_1 = sy[1];
    assign slot_y_2 = sy[2];
    assign slot_y_3 = sy[3];
    assign slot_y_4 = sy[4];
    assign slot_y_5 = sy[5];
    assign slot_w_0 = sw[0];
    assign slot_w_1 = sw[1];
    assign slot_w_2 = sw[2];
    assign slot_w_3 = sw[3];
    assign slot_w_4 = sw[4];
    assign slot_w_5 = sw[5];

    // Next window to the centre calculation
    assign next_x_0 = nx[0];
    assign next_x_1 = nx[1];
    assign next_x_2 = nx[2];
    assign next_x_3 = nx[3];
    assign next_x_4 = nx[4];
    assign next_x_5 = nx[5];
    assign next_y_0 = ny[0];
    assign next_y_1 = ny[1];
    assign next_y_2 = ny[2];
    assign next_y_3 = ny[3];
    assign next_y_4 = ny[4];
    assign next_y_5 = ny[5];
    assign next_w_0 = nw[0];
    assign next_w_1 = nw[1];
    assign next_w_2 = nw[2];
    assign next_w_3 = nw[3];
    assign next_w_4 = nw[4];
    assign next_w_5 = nw[5];

endmodule

`default_nettype wire

// ==== hdl/farthest_point_select.sv ====
// Squared distances of the six slots to the centre and tournament for the slot to replace
`default_nettype none

module farthest_point_select (
    input  wire gcc_point_pkg::coord_t    slot_x_0, slot_x_1, slot_x_2,
                                          slot_x_3, slot_x_4, slot_x_5,
    input  wire gcc_point_pkg::coord_t    slot_y_0, slot_y_1, slot_y_2,
                                          slot_y_3, slot_y_4, slot_y_5,
    input  wire gcc_point_pkg::weight_t   slot_w_0, slot_w_1, slot_w_2,
                                          slot_w_3, slot_w_4, slot_w_5,
    input  wire gcc_point_pkg::coord_t    cen_x,
    input  wire gcc_point_pkg::coord_t    cen_y,
    output gcc_point_pkg::slot_idx_t      victim
);

    import gcc_point_pkg::*;
    import gcc_arith_pkg::*;

    coord_t    sx [WINDOW_SLOTS];
    coord_t    sy [WINDOW_SLOTS];
    weight_t   sw [WINDOW_SLOTS];
    dist_t     d2 [WINDOW_SLOTS];
    slot_idx_t win_a;
    slot_idx_t win_b;
    slot_idx_t win_c;
    slot_idx_t win_ab;

    // Square of one axis offset
    function automatic dist_t axis_sq(input coord_t p, input coord_t c);
        coord_t d;
        d = (p >= c) ? p - c : c - p;
        return dist_t'(d) * dist_t'(d);
    endfunction

    // First operand wins on larger distance, then smaller X, Y, weight
    function automatic logic first_wins(
        input dist_t   da,
        input coord_t  xa,
        input coord_t  ya,
        input weight_t wa,
        input dist_t   db,
        input coord_t  xb,
        input coord_t  yb,
        input weight_t wb
    );
        if (da != db) begin
            return da > db;
        end
        if (xa != xb) begin
            return xa < xb;
        end
        if (ya != yb) begin
            return ya < yb;
        end
        return wa <= wb;
    endfunction

    assign sx = '{slot_x_0, slot_x_1, slot_x_2, slot_x_3, slot_x_4, slot_x_5};
    assign sy = '{slot_y_0, slot_y_1, slot_y_2, slot_y_3, slot_y_4, slot_y_5};
    assign sw = '{slot_w_0, slot_w_1, slot_w_2, slot_w_3, slot_w_4, slot_w_5};

    always_comb begin
        for (int i = 0; i < WINDOW_SLOTS; i++) begin
            d2[i] = axis_sq(sx[i], cen_x) + axis_sq(sy[i], cen_y);
        end
    end

    // ------------------------------------------------
    // Tournament
    // ------------------------------------------------
    always_comb begin
        // First round, slot 5 meets slot 0
        win_a = first_wins(d2[5], sx[5], sy[5], sw[5],
                           d2[0], sx[0], sy[0], sw[0]) ? slot_idx_t'(5) : slot_idx_t'(0);
        win_b = first_wins(d2[1], sx[1], sy[1], sw[1],
                           d2[2], sx[2], sy[2], sw[2]) ? slot_idx_t'(1) : slot_idx_t'(2);
        win_c = first_wins(d2[3], sx[3], sy[3], sw[3],
                           d2[4], sx[4], sy[4], sw[4]) ? slot_idx_t'(3) : slot_idx_t'(4);

        win_ab = first_wins(d2[win_a], sx[win_a], sy[win_a], sw[win_a],
                            d2[win_b], sx[win_b], sy[win_b], sw[win_b]) ? win_a : win_b;

        // Final against the third pair
        victim = first_wins(d2[win_ab], sx[win_ab], sy[win_ab], sw[win_ab],
                            d2[win_c], sx[win_c], sy[win_c], sw[win_c]) ? win_ab : win_c;
    end

endmodule

`default_nettype wire

// ==== hdl/centroid_calc.sv ====
// Weighted sums of the next window, rounded division and centre output registers
`default_nettype none

module centroid_calc (
    input  wire                         CLK,
    input  wire                         RESET_,
    input  wire gcc_point_pkg::coord_t  next_x_0, next_x_1, next_x_2,
                                        next_x_3, next_x_4, next_x_5,
    input  wire gcc_point_pkg::coord_t  next_y_0, next_y_1, next_y_2,
                                        next_y_3, next_y_4, next_y_5,
    input  wire gcc_point_pkg::weight_t next_w_0, next_w_1, next_w_2,
                                        next_w_3, next_w_4, next_w_5,
    output gcc_point_pkg::coord_t       xc,
    output gcc_point_pkg::coord_t       yc
);

    import gcc_point_pkg::*;
    import gcc_arith_pkg::*;

    coord_t  nx [WINDOW_SLOTS];
    coord_t  ny [WINDOW_SLOTS];
    weight_t nw [WINDOW_SLOTS];
    wsum_t   w_sum;
    csum_t   x_sum;
    csum_t   y_sum;

    function automatic csum_t prod(input coord_t c, input weight_t w);
        return csum_t'(c) * csum_t'(w);
    endfunction

    // Round to nearest, zero weight gives a zero centre
    function automatic coord_t round_div(input csum_t sum, input wsum_t w);
        dividend_t num;
        dividend_t quo;
        num = dividend_t'(sum) + dividend_t'(w >> 1);
        if (w == '0) begin
            return '0;
        end
        quo = num / dividend_t'(w);
        return coord_t'(quo);
    endfunction

    assign nx = '{next_x_0, next_x_1, next_x_2, next_x_3, next_x_4, next_x_5};
    assign ny = '{next_y_0, next_y_1, next_y_2, next_y_3, next_y_4, next_y_5};
    assign nw = '{next_w_0, next_w_1, next_w_2, next_w_3, next_w_4, next_w_5};

    // ------------------------------------------------
    // Balanced adder trees
    // ------------------------------------------------
    always_comb begin
        w_sum = (wsum_t'(nw[0]) + wsum_t'(nw[1]))
              + (wsum_t'(nw[2]) + wsum_t'(nw[3]))
              + (wsum_t'(nw[4]) + wsum_t'(nw[5]));
        x_sum = (prod(nx[0], nw[0]) + prod(nx[1], nw[1]))
              + (prod(nx[2], nw[2]) + prod(nx[3], nw[3]))
              + (prod(nx[4], nw[4]) + prod(nx[5], nw[5]));
        y_sum = (prod(ny[0], nw[0]) + prod(ny[1], nw[1]))
              + (prod(ny[2], nw[2]) + prod(ny[3], nw[3]))
              + (prod(ny[4], nw[4]) + prod(ny[5], nw[5]));
    end

    // Centre of the window the slots load at this edge
    always_ff @(posedge CLK or negedge RESET_) begin
        if (!RESET_) begin
            xc <= '0;
            yc <= '0;
        end else begin
            xc <= round_div(x_sum, w_sum);
            yc <= round_div(y_sum, w_sum);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gcc.sv ====
// Gravity-centre engine top level with the ready flag and the three datapath blocks
`default_nettype none

module gcc (
    input  wire                         CLK,
    input  wire                         RESET_,
    input  wire gcc_point_pkg::coord_t  xi,
    input  wire gcc_point_pkg::coord_t  yi,
    input  wire gcc_point_pkg::weight_t wi,
    output gcc_point_pkg::coord_t       xc,
    output gcc_point_pkg::coord_t       yc,
    output logic                        ready_
);

    import gcc_point_pkg::*;

    coord_t    slot_x_0, slot_x_1, slot_x_2, slot_x_3, slot_x_4, slot_x_5;
    coord_t    slot_y_0, slot_y_1, slot_y_2, slot_y_3, slot_y_4, slot_y_5;
    weight_t   slot_w_0, slot_w_1, slot_w_2, slot_w_3, slot_w_4, slot_w_5;
    coord_t    next_x_0, next_x_1, next_x_2, next_x_3, next_x_4, next_x_5;
    coord_t    next_y_0, next_y_1, next_y_2, next_y_3, next_y_4, next_y_5;
    weight_t   next_w_0, next_w_1, next_w_2, next_w_3, next_w_4, next_w_5;
    slot_idx_t victim;
    fill_cnt_t fill_cnt;

    // ------------------------------------------------
    // Ready flag
    // ------------------------------------------------
    // Drops one edge after the first count, then stays low
    always_ff @(posedge CLK or negedge RESET_) begin
        if (!RESET_) begin
            ready_ <= 1'b1;
        end else begin
            ready_ <= (fill_cnt == '0);
        end
    end

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------
    // Pending point stays inside the window block
    point_window i_point_window (
        .pend_x (),
        .pend_y (),
        .pend_w (),
        .*
    );

    // Victim is measured against the registered centre
    farthest_point_select i_farthest_point_select (
        .cen_x (xc),
        .cen_y (yc),
        .*
    );

    centroid_calc i_centroid_calc (
        .*
    );

endmodule

`default_nettype wire

// ==== tb/gcc_sva.sv ====
// Bound assertions on reset values of the centre, the ready flag and the fill counter
`default_nettype none

module gcc_sva (
    input wire                           CLK,
    input wire                           RESET_,
    input wire                           ready_,
    input wire gcc_point_pkg::fill_cnt_t fill_cnt,
    input wire gcc_point_pkg::coord_t    xc,
    input wire gcc_point_pkg::coord_t    yc
);

    timeunit 1ns;
    timeprecision 100ps;

    // Registered flag lags the counter by one edge
    ready_low: assert property (@(posedge CLK) disable iff (!RESET_)
        fill_cnt != '0 |=> !ready_)
        else $error("ready_ still high after the fill count reached one");

    fill_no_decrease: assert property (@(posedge CLK) disable iff (!RESET_)
        fill_cnt >= $past(fill_cnt))
        else $error("fill count went down without a reset");

    centre_zero_after_reset: assert property (@(posedge CLK)
        $rose(RESET_) |-> (xc == '0 && yc == '0))
        else $error("centre not zero in the cycle after reset");

endmodule

bind gcc gcc_sva i_gcc_sva (
    .CLK      (CLK),
    .RESET_   (RESET_),
    .ready_   (ready_),
    .fill_cnt (fill_cnt),
    .xc       (xc),
    .yc       (yc)
);

`default_nettype wire

// ==== tb/tb_gcc.sv ====
// Testbench for the gravity-centre engine with reference model, directed tests and verdict
`default_nettype none

module tb_gcc;

    timeunit 1ns;
    timeprecision 100ps;

    import gcc_point_pkg::*;
    import gcc_arith_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int STREAM_LEN    = 200;
    // Reset and point cycles of each test, in run order
    localparam int TEST_CYCLES   = 5 + 6 + 14 + 11 + 11 + 3 + STREAM_LEN;
    localparam int MARGIN_CYCLES = 50;

    logic    CLK;
    logic    RESET_;
    coord_t  xi;
    coord_t  yi;
    weight_t wi;
    coord_t  xc;
    coord_t  yc;
    logic    ready_;

    int          errors;
    logic [15:0] lfsr;

    // ------------------------------------------------
    // Reference model state
    // ------------------------------------------------
    int   m_x [WINDOW_SLOTS];
    int   m_y [WINDOW_SLOTS];
    int   m_w [WINDOW_SLOTS];
    int   m_px;
    int   m_py;
    int   m_pw;
    int   m_fill;
    int   m_cx;
    int   m_cy;
    logic m_ready;
    // Point on the DUT inputs at the coming edge
    int   in_x;
    int   in_y;
    int   in_w;

    gcc i_gcc (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int round_centre(input int sum, input int wsum);
        if (wsum == 0) begin
            return 0;
        end
        return (sum + wsum / 2) / wsum;
    endfunction

    // Slot a lies farther out than slot b, ties by smaller X, Y, weight
    function automatic logic farther(input int a, input int b);
        int da;
        int db;
        da = (m_x[a] - m_cx) * (m_x[a] - m_cx) + (m_y[a] - m_cy) * (m_y[a] - m_cy);
        db = (m_x[b] - m_cx) * (m_x[b] - m_cx) + (m_y[b] - m_cy) * (m_y[b] - m_cy);
        if (da != db) begin
            return da > db;
        end
        if (m_x[a] != m_x[b]) begin
            return m_x[a] < m_x[b];
        end
        if (m_y[a] != m_y[b]) begin
            return m_y[a] < m_y[b];
        end
        return m_w[a] < m_w[b];
    endfunction

    task automatic model_clear(input int x, input int y, input int w);
        for (int i = 0; i < WINDOW_SLOTS; i++) begin
            m_x[i] = 0;
            m_y[i] = 0;
            m_w[i] = 0;
        end
        m_px    = 0;
        m_py    = 0;
        m_pw    = 0;
        m_fill  = 0;
        m_cx    = 0;
        m_cy    = 0;
        m_ready = 1'b1;
        in_x    = x;
        in_y    = y;
        in_w    = w;
    endtask

    // One rising edge of the engine
    task automatic model_clock();
        int victim;
        int x_sum;
        int y_sum;
        int w_sum;
        m_ready = (m_fill == 0);
        if (m_fill < int'(FILL_DONE)) begin
            for (int i = WINDOW_SLOTS - 1; i > 0; i--) begin
                m_x[i] = m_x[i - 1];
                m_y[i] = m_y[i - 1];
                m_w[i] = m_w[i - 1];
            end
            m_x[0] = m_px;
            m_y[0] = m_py;
            m_w[0] = m_pw;
            m_fill++;
        end else begin
            victim = 0;
            for (int i = 1; i < WINDOW_SLOTS; i++) begin
                if (farther(i, victim)) begin
                    victim = i;
                end
            end
            m_x[victim] = m_px;
            m_y[victim] = m_py;
            m_w[victim] = m_pw;
        end
        x_sum = 0;
        y_sum = 0;
        w_sum = 0;
        for (int i = 0; i < WINDOW_SLOTS; i++) begin
            x_sum += m_x[i] * m_w[i];
            y_sum += m_y[i] * m_w[i];
            w_sum += m_w[i];
        end
        m_cx = round_centre(x_sum, w_sum);
        m_cy = round_centre(y_sum, w_sum);
        m_px = in_x;
        m_py = in_y;
        m_pw = in_w;
    endtask

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------
    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic apply_reset(input int x, input int y, input int w);
        @(posedge CLK);
        RESET_ <= 1'b0;
        xi     <= coord_t'(x);
        yi     <= coord_t'(y);
        wi     <= weight_t'(w);
        repeat (2) @(posedge CLK);
        RESET_ <= 1'b1;
        model_clear(x, y, w);
    endtask

    // Drives the next point, steps the model and compares at the falling edge
    task automatic drive_point(input string name, input int x, input int y, input int w);
        @(posedge CLK);
        xi <= coord_t'(x);
        yi <= coord_t'(y);
        wi <= weight_t'(w);
        model_clock();
        in_x = x;
        in_y = y;
        in_w = w;
        @(negedge CLK);
        check_coord({name, " xc"}, coord_t'(m_cx), xc);
        check_coord({name, " yc"}, coord_t'(m_cy), yc);
        check_ready({name, " ready_"}, m_ready, ready_);
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic reset_values();
        apply_reset(0, 0, 0);
        @(negedge CLK);
        check_coord("reset xc", 8'd0, xc);
        check_coord("reset yc", 8'd0, yc);
        check_ready("reset ready_", 1'b1, ready_);
        drive_point("reset", 0, 0, 0);
        drive_point("reset", 0, 0, 0);
        check_ready("reset second edge", 1'b0, ready_);
    endtask

    task automatic single_point();
        apply_reset(0, 0, 0);
        drive_point("single", 77, 150, 9);
        drive_point("single", 0, 0, 0);
        drive_point("single", 0, 0, 0);
        check_coord("single point xc", 8'd77, xc);
        check_coord("single point yc", 8'd150, yc);
    endtask

    task automatic rounding();
        apply_reset(0, 0, 0);
        drive_point("round 1:1", 10, 0, 1);
        drive_point("round 1:1", 13, 0, 1);
        drive_point("round 1:1", 0, 0, 0);
        drive_point("round 1:1", 0, 0, 0);
        check_coord("rounding 1:1 xc", 8'd12, xc);
        apply_reset(0, 0, 0);
        drive_point("round 3:1", 10, 0, 3);
        drive_point("round 3:1", 13, 0, 1);
        drive_point("round 3:1", 0, 0, 0);
        drive_point("round 3:1", 0, 0, 0);
        check_coord("rounding 3:1 xc", 8'd11, xc);
    endtask

    // Outlier at (200,200) gives way to a point near the cluster
    task automatic farthest_replace();
        apply_reset(0, 0, 0);
        drive_point("replace", 5, 5, 2);
        drive_point("replace", 6, 5, 2);
        drive_point("replace", 5, 6, 2);
        drive_point("replace", 6, 6, 2);
        drive_point("replace", 200, 200, 2);
        drive_point("replace", 4, 4, 2);
        drive_point("replace", 5, 5, 2);
        drive_point("replace", 5, 5, 2);
        check_coord("replace centre xc", 8'd5, xc);
        check_coord("replace centre yc", 8'd5, yc);
    endtask

    // Slots at x 60 and 140 tie, the one at 60 must go
    task automatic tie_break();
        apply_reset(100, 100, 4);
        drive_point("tie", 100, 100, 4);
        drive_point("tie", 100, 100, 4);
        drive_point("tie", 100, 100, 4);
        drive_point("tie", 60, 100, 1);
        drive_point("tie", 140, 100, 1);
        drive_point("tie", 100, 100, 4);
        drive_point("tie", 100, 100, 4);
        drive_point("tie", 100, 100, 4);
        check_coord("tie-break xc", 8'd102, xc);
        check_coord("tie-break yc", 8'd100, yc);
    endtask

    task automatic random_stream();
        int x;
        int y;
        int w;
        apply_reset(0, 0, 0);
        for (int n = 0; n < STREAM_LEN; n++) begin
            draw_bits(8, x);
            draw_bits(8, y);
            draw_bits(4, w);
            drive_point("random", x, y, w);
        end
    endtask

    initial begin
        RESET_ <= 1'b0;
        xi     <= '0;
        yi     <= '0;
        wi     <= '0;
        errors = 0;
        lfsr   = 16'd62066;
        model_clear(0, 0, 0);
        reset_values();
        single_point();
        rounding();
        farthest_replace();
        tie_break();
        random_stream();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/gcc_point_pkg.sv
hdl/gcc_arith_pkg.sv
hdl/point_window.sv
hdl/farthest_point_select.sv
hdl/centroid_calc.sv
hdl/gcc.sv
tb/gcc_sva.sv
tb/tb_gcc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the gravity-centre testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_gcc -o sim_tb_gcc

out=$(./obj_dir/sim_tb_gcc)
echo "$out"

if grep -qxF -- "** PASS **" <<< "$out"; then
    exit 0
fi
exit 1
